//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CMD_W      = 4;
    localparam int MEM_ADDR_W = 8;
    localparam int MEM_WORDS  = 256;

    // Execute commands from the decoder
    localparam logic [CMD_W-1:0] CMD_NONE  = 4'd0;
    localparam logic [CMD_W-1:0] CMD_ADD   = 4'd1;
    localparam logic [CMD_W-1:0] CMD_EQU   = 4'd2;
    localparam logic [CMD_W-1:0] CMD_LOAD  = 4'd3;
    localparam logic [CMD_W-1:0] CMD_STORE = 4'd4;
    localparam logic [CMD_W-1:0] CMD_HALT  = 4'd5;

    localparam logic [6:0] OP_IMM    = 7'b00100_11;
    localparam logic [6:0] OP_REG    = 7'b01100_11;
    localparam logic [6:0] OP_LUI    = 7'b01101_11;
    localparam logic [6:0] OP_AUIPC  = 7'b00101_11;
    localparam logic [6:0] OP_LOAD   = 7'b00000_11;
    localparam logic [6:0] OP_STORE  = 7'b01000_11;
    localparam logic [6:0] OP_SYSTEM = 7'b11100_11;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_U,
        IMM_S
    } imm_kind_t;

    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;   // Word address
        logic [XLEN-1:0]       wdata;
    } mem_req_t;

    typedef struct packed {
        logic [CMD_W-1:0]      cmd;
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage

`default_nettype wire

//--- source/unified_mem.sv
`default_nettype none

module unified_mem (
    input  logic                     clk,
    input  cpu_pkg::mem_req_t        mem_req,
    output logic [cpu_pkg::XLEN-1:0] rdata
);

    logic [cpu_pkg::XLEN-1:0] mem [cpu_pkg::MEM_WORDS];

    always_ff @(posedge clk) begin
        if (mem_req.req) begin
            if (mem_req.we) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rdata <= mem[mem_req.addr];    // Valid the cycle after grant
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_pkg::mem_req_t        host_req,
    input  cpu_pkg::mem_req_t        lsu_req,
    input  cpu_pkg::mem_req_t        ifu_req,
    output cpu_pkg::mem_req_t        mem_req,
    input  logic [cpu_pkg::XLEN-1:0] mem_rdata,
    output logic                     host_grant,
    output logic                     lsu_grant,
    output logic                     ifu_grant,
    output logic                     host_rvalid,
    output logic                     lsu_rvalid,
    output logic                     ifu_rvalid,
    output logic [cpu_pkg::XLEN-1:0] rdata
);

    // Host first, then load/store, then fetch
    assign host_grant = host_req.req;
    assign lsu_grant  = lsu_req.req && !host_req.req;
    assign ifu_grant  = ifu_req.req && !host_req.req && !lsu_req.req;

    always_comb begin
        if (host_grant) begin
            mem_req = host_req;
        end else if (lsu_grant) begin
            mem_req = lsu_req;
        end else if (ifu_grant) begin
            mem_req = ifu_req;
        end else begin
            mem_req = '0;
        end
    end

    // Owner tag for the read in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_rvalid <= 1'b0;
            lsu_rvalid  <= 1'b0;
            ifu_rvalid  <= 1'b0;
        end else begin
            host_rvalid <= host_grant && !host_req.we;
            lsu_rvalid  <= lsu_grant && !lsu_req.we;
            ifu_rvalid  <= ifu_grant && !ifu_req.we;
        end
    end

    assign rdata = mem_rdata;

    // Losing request held with its address until granted
    a_lsu_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_req.req && !lsu_grant |=> lsu_req.req && $stable(lsu_req.addr));

    a_ifu_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        ifu_req.req && !ifu_grant |=> ifu_req.req && $stable(ifu_req.addr));

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_start,
    input  logic [cpu_pkg::XLEN-1:0] next_pc,
    output cpu_pkg::mem_req_t        ifu_req,
    input  logic                     ifu_grant,
    input  logic                     ifu_rvalid,
    input  logic [cpu_pkg::XLEN-1:0] rdata,
    output logic [cpu_pkg::XLEN-1:0] instr,
    output logic [cpu_pkg::XLEN-1:0] pc,
    output logic                     instr_valid
);

    logic                           req_q;
    logic [cpu_pkg::MEM_ADDR_W-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            pc    <= '0;
        end else if (fetch_start) begin
            req_q <= 1'b1;
            pc    <= next_pc;
        end else if (ifu_grant) begin
            req_q <= 1'b0;      // Held until granted
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            addr_q <= next_pc[cpu_pkg::MEM_ADDR_W+1:2];
        end
        if (ifu_rvalid) begin
            instr <= rdata;
        end
    end

    assign ifu_req.req   = req_q;
    assign ifu_req.we    = 1'b0;
    assign ifu_req.addr  = addr_q;
    assign ifu_req.wdata = '0;

    assign instr_valid = ifu_rvalid;

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`default_nettype none

module decode_unit (
    input  logic [cpu_pkg::XLEN-1:0]       instr,
    input  logic [cpu_pkg::XLEN-1:0]       pc,
    input  logic [cpu_pkg::XLEN-1:0]       rdata1,
    input  logic [cpu_pkg::XLEN-1:0]       rdata2,
    output logic [cpu_pkg::REG_ADDR_W-1:0] raddr1,
    output logic [cpu_pkg::REG_ADDR_W-1:0] raddr2,
    output cpu_pkg::decode_t               dec
);

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic                     rs1_en;
    logic                     rs2_en;
    cpu_pkg::imm_kind_t       imm_kind;
    logic [cpu_pkg::XLEN-1:0] imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign rs1_en = opcode == cpu_pkg::OP_IMM || opcode == cpu_pkg::OP_REG
                 || opcode == cpu_pkg::OP_LOAD || opcode == cpu_pkg::OP_STORE;
    assign rs2_en = opcode == cpu_pkg::OP_REG || opcode == cpu_pkg::OP_STORE;

    assign raddr1 = rs1_en ? instr[19:15] : '0;
    assign raddr2 = rs2_en ? instr[24:20] : '0;

    always_comb begin
        case (opcode)
            cpu_pkg::OP_IMM, cpu_pkg::OP_LOAD: imm_kind = cpu_pkg::IMM_I;
            cpu_pkg::OP_LUI, cpu_pkg::OP_AUIPC: imm_kind = cpu_pkg::IMM_U;
            cpu_pkg::OP_STORE: imm_kind = cpu_pkg::IMM_S;
            default: imm_kind = cpu_pkg::IMM_NONE;
        endcase
    end

    always_comb begin
        case (imm_kind)
            cpu_pkg::IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            cpu_pkg::IMM_U: imm = {instr[31:12], 12'b0};
            cpu_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            default: imm = '0;
        endcase
    end

    always_comb begin
        dec     = '0;
        dec.cmd = cpu_pkg::CMD_NONE;
        case (opcode)
            cpu_pkg::OP_IMM: begin
                if (funct3 == 3'b000) begin     // addi
                    dec.cmd  = cpu_pkg::CMD_ADD;
                    dec.src1 = imm;
                    dec.src2 = rdata1;
                    dec.wen  = 1'b1;
                end
            end
            cpu_pkg::OP_REG: begin
                if (funct3 == 3'b000 && instr[31:25] == 7'b0) begin
                    dec.cmd  = cpu_pkg::CMD_ADD;
                    dec.src1 = rdata1;
                    dec.src2 = rdata2;
                    dec.wen  = 1'b1;
                end
            end
            cpu_pkg::OP_LUI: begin
                dec.cmd  = cpu_pkg::CMD_EQU;
                dec.src1 = imm;
                dec.wen  = 1'b1;
            end
            cpu_pkg::OP_AUIPC: begin
                dec.cmd  = cpu_pkg::CMD_ADD;
                dec.src1 = pc;
                dec.src2 = imm;
                dec.wen  = 1'b1;
            end
            cpu_pkg::OP_LOAD: begin
                if (funct3 == 3'b010) begin     // lw only
                    dec.cmd  = cpu_pkg::CMD_LOAD;
                    dec.src1 = rdata1;
                    dec.src2 = imm;
                    dec.wen  = 1'b1;
                end
            end
            cpu_pkg::OP_STORE: begin
                if (funct3 == 3'b010) begin     // sw only
                    dec.cmd        = cpu_pkg::CMD_STORE;
                    dec.src1       = rdata1;
                    dec.src2       = imm;
                    dec.store_data = rdata2;
                end
            end
            cpu_pkg::OP_SYSTEM: begin
                if (instr[31:7] == 25'h0002000) begin   // ebreak
                    dec.cmd = cpu_pkg::CMD_HALT;
                end
            end
            default: ;
        endcase
        dec.rd = dec.wen ? instr[11:7] : '0;
    end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [cpu_pkg::XLEN-1:0]       rdata1,
    output logic [cpu_pkg::XLEN-1:0]       rdata2,
    input  logic                           wen,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [cpu_pkg::XLEN-1:0]       wdata
);

    logic [cpu_pkg::XLEN-1:0] regs [2**cpu_pkg::REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**cpu_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;       // x0 stays zero
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0));

endmodule

`default_nettype wire

//--- source/load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  cpu_pkg::decode_t         dec,
    output cpu_pkg::mem_req_t        lsu_req,
    input  logic                     lsu_grant,
    input  logic                     lsu_rvalid,
    input  logic [cpu_pkg::XLEN-1:0] rdata,
    output logic                     done,
    output logic [cpu_pkg::XLEN-1:0] load_data
);

    logic [cpu_pkg::XLEN-1:0] byte_addr;

    assign byte_addr = dec.src1 + dec.src2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsu_req.req <= 1'b0;
        end else if (start) begin
            lsu_req.req <= 1'b1;
        end else if (lsu_grant) begin
            lsu_req.req <= 1'b0;
        end
        if (start) begin
            lsu_req.we    <= dec.cmd == cpu_pkg::CMD_STORE;
            lsu_req.addr  <= byte_addr[cpu_pkg::MEM_ADDR_W+1:2];
            lsu_req.wdata <= dec.store_data;
        end
    end

    // Store ends on grant, load on returned data
    assign done      = (lsu_grant && lsu_req.we) || lsu_rvalid;
    assign load_data = rdata;

endmodule

`default_nettype wire

//--- source/core_ctrl.sv
`default_nettype none

module core_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           instr_valid,
    input  logic [cpu_pkg::XLEN-1:0]       pc,
    input  cpu_pkg::decode_t               dec,
    input  logic                           lsu_done,
    input  logic [cpu_pkg::XLEN-1:0]       load_data,
    output logic                           fetch_start,
    output logic [cpu_pkg::XLEN-1:0]       next_pc,
    output logic                           lsu_start,
    output logic                           wen,
    output logic [cpu_pkg::REG_ADDR_W-1:0] waddr,
    output logic [cpu_pkg::XLEN-1:0]       wdata,
    output cpu_pkg::retire_t               retire,
    output logic                           retire_valid,
    output logic                           halted
);

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_MEM, S_HALT} state_t;

    state_t                   state;
    state_t                   state_nxt;
    logic                     is_mem;
    logic [cpu_pkg::XLEN-1:0] alu_result;

    assign is_mem = dec.cmd == cpu_pkg::CMD_LOAD || dec.cmd == cpu_pkg::CMD_STORE;

    always_comb begin
        case (dec.cmd)
            cpu_pkg::CMD_ADD: alu_result = dec.src1 + dec.src2;
            cpu_pkg::CMD_EQU: alu_result = dec.src1;
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        state_nxt    = state;
        fetch_start  = 1'b0;
        lsu_start    = 1'b0;
        retire_valid = 1'b0;
        case (state)
            S_IDLE: begin
                if (run) begin
                    fetch_start = 1'b1;
                    state_nxt   = S_FETCH;
                end
            end
            S_FETCH: begin
                if (instr_valid) begin
                    state_nxt = S_EXEC;
                end
            end
            S_EXEC: begin
                if (is_mem) begin
                    lsu_start = 1'b1;
                    state_nxt = S_MEM;
                end else begin
                    retire_valid = 1'b1;
                    if (dec.cmd == cpu_pkg::CMD_HALT) begin
                        state_nxt = S_HALT;
                    end else begin
                        fetch_start = 1'b1;
                        state_nxt   = S_FETCH;
                    end
                end
            end
            S_MEM: begin
                if (lsu_done) begin
                    retire_valid = 1'b1;
                    fetch_start  = 1'b1;
                    state_nxt    = S_FETCH;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign next_pc = (state == S_IDLE) ? '0 : pc + 32'd4;   // First fetch from 0
    assign wdata   = (dec.cmd == cpu_pkg::CMD_LOAD) ? load_data : alu_result;
    assign wen     = retire_valid && dec.wen;
    assign waddr   = dec.rd;

    assign retire.pc   = pc;
    assign retire.rd   = dec.rd;
    assign retire.wen  = dec.wen;
    assign retire.data = wdata;

    assign halted = state == S_HALT || (state == S_EXEC && dec.cmd == cpu_pkg::CMD_HALT);

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted);

endmodule

`default_nettype wire

//--- source/rv_core_top.sv
`default_nettype none

module rv_core_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  cpu_pkg::mem_req_t        host_req,
    output logic                     host_grant,
    output logic                     host_rvalid,
    output logic [cpu_pkg::XLEN-1:0] host_rdata,
    output logic                     retire_valid,
    output cpu_pkg::retire_t         retire,
    output logic                     halted
);

    cpu_pkg::mem_req_t              mem_req;
    cpu_pkg::mem_req_t              lsu_req;
    cpu_pkg::mem_req_t              ifu_req;
    cpu_pkg::decode_t               dec;
    logic [cpu_pkg::XLEN-1:0]       mem_rdata;
    logic [cpu_pkg::XLEN-1:0]       rdata;
    logic                           lsu_grant;
    logic                           ifu_grant;
    logic                           lsu_rvalid;
    logic                           ifu_rvalid;
    logic                           fetch_start;
    logic [cpu_pkg::XLEN-1:0]       next_pc;
    logic [cpu_pkg::XLEN-1:0]       instr;
    logic [cpu_pkg::XLEN-1:0]       pc;
    logic                           instr_valid;
    logic [cpu_pkg::REG_ADDR_W-1:0] raddr1;
    logic [cpu_pkg::REG_ADDR_W-1:0] raddr2;
    logic [cpu_pkg::XLEN-1:0]       rdata1;
    logic [cpu_pkg::XLEN-1:0]       rdata2;
    logic                           lsu_start;
    logic                           lsu_done;
    logic [cpu_pkg::XLEN-1:0]       load_data;
    logic                           wen;
    logic [cpu_pkg::REG_ADDR_W-1:0] waddr;
    logic [cpu_pkg::XLEN-1:0]       wdata;

    assign host_rdata = rdata;

    unified_mem u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_req    (host_req),
        .lsu_req     (lsu_req),
        .ifu_req     (ifu_req),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .host_grant  (host_grant),
        .lsu_grant   (lsu_grant),
        .ifu_grant   (ifu_grant),
        .host_rvalid (host_rvalid),
        .lsu_rvalid  (lsu_rvalid),
        .ifu_rvalid  (ifu_rvalid),
        .rdata       (rdata)
    );

    fetch_unit u_ifu (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .next_pc     (next_pc),
        .ifu_req     (ifu_req),
        .ifu_grant   (ifu_grant),
        .ifu_rvalid  (ifu_rvalid),
        .rdata       (rdata),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid)
    );

    decode_unit u_idu (
        .instr  (instr),
        .pc     (pc),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .dec    (dec)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (lsu_start),
        .dec        (dec),
        .lsu_req    (lsu_req),
        .lsu_grant  (lsu_grant),
        .lsu_rvalid (lsu_rvalid),
        .rdata      (rdata),
        .done       (lsu_done),
        .load_data  (load_data)
    );

    core_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .instr_valid  (instr_valid),
        .pc           (pc),
        .dec          (dec),
        .lsu_done     (lsu_done),
        .load_data    (load_data),
        .fetch_start  (fetch_start),
        .next_pc      (next_pc),
        .lsu_start    (lsu_start),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .retire       (retire),
        .retire_valid (retire_valid),
        .halted       (halted)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;      // Period of 4
        end
    end

endmodule

`default_nettype wire

//--- tb/rv_core_tb.sv
`default_nettype none

module rv_core_tb;

    localparam int TOTAL_INSTR = 74;    // Sum of all test program lengths
    localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR + 2000;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic                     clk;
    logic                     rst_n;
    logic                     run;
    cpu_pkg::mem_req_t        host_req;
    logic                     host_grant;
    logic                     host_rvalid;
    logic [cpu_pkg::XLEN-1:0] host_rdata;
    logic                     retire_valid;
    cpu_pkg::retire_t         retire;
    logic                     halted;

    logic [31:0]      prog [$];
    cpu_pkg::retire_t exp_retire [$];
    cpu_pkg::retire_t exp_head;
    logic [31:0]      model_mem [cpu_pkg::MEM_WORDS];
    bit               model_known [cpu_pkg::MEM_WORDS];
    int               cycles = 0;

    tb_clock u_clk (.clk(clk));

    rv_core_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .host_req     (host_req),
        .host_grant   (host_grant),
        .host_rvalid  (host_rvalid),
        .host_rdata   (host_rdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], cpu_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] add_word(input int rd, input int rs1, input int rs2);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], cpu_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] lw_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], cpu_pkg::OP_LOAD};
    endfunction

    function automatic logic [31:0] sw_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], cpu_pkg::OP_STORE};
    endfunction

    // Runs the program on a register array and queues every expected retire
    task automatic predict_program();
        logic [31:0]      x [32];
        logic [31:0]      pc;
        logic [31:0]      ins;
        logic [31:0]      addr;
        logic [31:0]      imm_i;
        logic [31:0]      imm_s;
        cpu_pkg::retire_t r;
        bit               stop;
        int               steps;
        foreach (x[i]) x[i] = '0;
        pc = '0;
        stop = 1'b0;
        steps = 0;
        while (!stop && steps < 1000) begin
            ins   = model_mem[pc[9:2]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            r     = '0;
            r.pc  = pc;
            if (ins[6:0] == cpu_pkg::OP_IMM && ins[14:12] == 3'b000) begin
                r.wen  = 1'b1;
                r.data = x[ins[19:15]] + imm_i;
            end else if (ins[6:0] == cpu_pkg::OP_REG && ins[14:12] == 3'b000
                         && ins[31:25] == 7'b0) begin
                r.wen  = 1'b1;
                r.data = x[ins[19:15]] + x[ins[24:20]];
            end else if (ins[6:0] == cpu_pkg::OP_LUI) begin
                r.wen  = 1'b1;
                r.data = {ins[31:12], 12'b0};
            end else if (ins[6:0] == cpu_pkg::OP_AUIPC) begin
                r.wen  = 1'b1;
                r.data = pc + {ins[31:12], 12'b0};
            end else if (ins[6:0] == cpu_pkg::OP_LOAD && ins[14:12] == 3'b010) begin
                addr   = x[ins[19:15]] + imm_i;
                r.wen  = 1'b1;
                r.data = model_mem[addr[9:2]];
            end else if (ins[6:0] == cpu_pkg::OP_STORE && ins[14:12] == 3'b010) begin
                addr = x[ins[19:15]] + imm_s;
                model_mem[addr[9:2]]   = x[ins[24:20]];
                model_known[addr[9:2]] = 1'b1;
            end else if (ins == EBREAK) begin
                stop = 1'b1;
            end
            if (r.wen) begin
                r.rd = ins[11:7];
                if (r.rd != '0) x[r.rd] = r.data;
            end
            exp_retire.push_back(r);
            pc = pc + 32'd4;
            steps++;
        end
    endtask

    task automatic host_write(input int word, input logic [31:0] data);
        @(negedge clk);
        host_req.req   = 1'b1;
        host_req.we    = 1'b1;
        host_req.addr  = word[7:0];
        host_req.wdata = data;
        @(posedge clk);
        while (!host_grant) @(posedge clk);
        @(negedge clk);
        host_req = '0;
    endtask

    task automatic host_read(input int word, output logic [31:0] data);
        @(negedge clk);
        host_req.req   = 1'b1;
        host_req.we    = 1'b0;
        host_req.addr  = word[7:0];
        host_req.wdata = '0;
        @(posedge clk);
        while (!host_grant) @(posedge clk);
        @(negedge clk);
        host_req = '0;
        @(posedge clk);
        while (!host_rvalid) @(posedge clk);
        data = host_rdata;
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_n    = 1'b0;
        run      = 1'b0;
        host_req = '0;
        exp_retire.delete();
        prog.delete();
        foreach (model_known[i]) model_known[i] = 1'b0;
        repeat (4) @(negedge clk);
        assert (!retire_valid && !halted && !host_rvalid)
            else fail_run("Outputs not idle during reset");
        rst_n = 1'b1;
    endtask

    // Data word known to both the DUT memory and the model
    task automatic preload(input int word, input logic [31:0] data);
        host_write(word, data);
        model_mem[word]   = data;
        model_known[word] = 1'b1;
    endtask

    task automatic load_program();
        foreach (prog[i]) preload(i, prog[i]);
        predict_program();
        @(negedge clk);
        run = 1'b1;
    endtask

    task automatic wait_halt();
        @(posedge clk);
        while (!halted) @(posedge clk);
        @(negedge clk);
        assert (exp_retire.size() == 0)
            else fail_run($sformatf("Core halted with %0d expected retires missing",
                                    exp_retire.size()));
    endtask

    task automatic check_memory();
        logic [31:0] got;
        for (int w = 0; w < cpu_pkg::MEM_WORDS; w++) begin
            if (model_known[w]) begin
                host_read(w, got);
                assert (got == model_mem[w])
                    else fail_run($sformatf("MISMATCH host_rdata word %h: got %h expected %h",
                                            w, got, model_mem[w]));
            end
        end
    endtask

    // Random host reads and writes of words the program never touches
    task automatic host_traffic();
        int          word;
        logic [31:0] got;
        logic [31:0] value;
        while (!halted) begin
            word = 200 + $urandom_range(0, 31);
            if ($urandom_range(0, 3) == 0) begin
                value = $urandom();
                host_write(word, value);
                model_mem[word] = value;
            end else begin
                host_read(word, got);
                assert (got == model_mem[word])
                    else fail_run($sformatf("MISMATCH host_rdata word %h: got %h expected %h",
                                            word, got, model_mem[word]));
            end
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end
    endtask

    task automatic alu_sequence();
        reset_dut();
        prog = '{addi_word(1, 0, 5), addi_word(2, 0, -3), add_word(3, 1, 2),
                 upper_word(cpu_pkg::OP_LUI, 4, 'hABCDE),
                 upper_word(cpu_pkg::OP_AUIPC, 5, 'h12),
                 addi_word(6, 4, -1), add_word(7, 3, 4), EBREAK};
        load_program();
        wait_halt();
    endtask

    task automatic x0_handling();
        reset_dut();
        prog = '{addi_word(0, 0, 7), addi_word(1, 0, 9), add_word(2, 0, 1),
                 add_word(3, 1, 0), EBREAK};
        load_program();
        wait_halt();
    endtask

    task automatic load_store_roundtrip();
        reset_dut();
        preload(64, 32'h1234_5678);
        prog = '{addi_word(1, 0, 256), lw_word(2, 1, 0), addi_word(3, 2, 1), sw_word(3, 1, 4),
                 sw_word(2, 1, -4), lw_word(4, 1, 4), add_word(5, 4, 2), sw_word(5, 1, 8),
                 EBREAK};
        load_program();
        wait_halt();
        check_memory();
    endtask

    task automatic unsupported_opcodes();
        reset_dut();
        prog = '{addi_word(1, 0, 1), 32'h0000_007F, addi_word(2, 1, 5) | 32'h0000_2000,
                 32'hFFFF_FFFF, 32'h0000_0000, add_word(3, 1, 0), add_word(4, 2, 1), EBREAK};
        load_program();
        wait_halt();
    endtask

    task automatic halt_and_hold();
        reset_dut();
        prog = '{addi_word(1, 0, 3), EBREAK, addi_word(2, 0, 4)};
        load_program();
        wait_halt();
        repeat (50) begin
            @(posedge clk);
            assert (halted && !retire_valid)
                else fail_run("Core left halt or retired an instruction after ebreak");
        end
    endtask

    task automatic shared_memory_contention();
        int kind;
        reset_dut();
        for (int w = 200; w < 232; w++) preload(w, $urandom());
        for (int i = 0; i < 40; i++) begin
            kind = $urandom_range(0, 3);
            case (kind)
                0: prog.push_back(addi_word($urandom_range(1, 7), $urandom_range(0, 7),
                                            $urandom_range(0, 4095)));
                1: prog.push_back(add_word($urandom_range(1, 7), $urandom_range(0, 7),
                                           $urandom_range(0, 7)));
                2: prog.push_back(upper_word(cpu_pkg::OP_LUI, $urandom_range(1, 7),
                                             $urandom_range(0, 'hFFFFF)));
                default: prog.push_back(sw_word($urandom_range(0, 7), 0,
                                                4 * (128 + $urandom_range(0, 31))));
            endcase
        end
        prog.push_back(EBREAK);
        load_program();
        fork
            wait_halt();
            host_traffic();
        join
        check_memory();
    endtask

    // Retire monitor
    always @(posedge clk) begin
        if (rst_n && retire_valid) begin
            assert (exp_retire.size() > 0)
                else fail_run("Instruction retired when none was expected");
            exp_head = exp_retire.pop_front();
            assert (retire.pc == exp_head.pc)
                else fail_run($sformatf("MISMATCH retire.pc: got %h expected %h",
                                        retire.pc, exp_head.pc));
            assert (retire.wen == exp_head.wen)
                else fail_run($sformatf("MISMATCH retire.wen: got %h expected %h",
                                        retire.wen, exp_head.wen));
            if (exp_head.wen) begin
                assert (retire.rd == exp_head.rd)
                    else fail_run($sformatf("MISMATCH retire.rd: got %h expected %h",
                                            retire.rd, exp_head.rd));
                assert (retire.data == exp_head.data)
                    else fail_run($sformatf("MISMATCH retire.data: got %h expected %h",
                                            retire.data, exp_head.data));
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            fail_run("Timeout, the tests did not finish within the cycle limit");
        end
    end

    initial begin
        rst_n    = 1'b0;
        run      = 1'b0;
        host_req = '0;
        void'($urandom(48379));
        alu_sequence();
        x0_handling();
        load_store_roundtrip();
        unsupported_opcodes();
        halt_and_hold();
        shared_memory_contention();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_core_top.f
source/cpu_pkg.sv
source/unified_mem.sv
source/mem_arbiter.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/load_store_unit.sv
source/core_ctrl.sv
source/rv_core_top.sv
tb/tb_clock.sv
tb/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rv_core_tb \
    -f rv_core_top.f -o rv_core_sim > build.log 2>&1 \
    && ./obj_dir/rv_core_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation finished without errors"
